// File: hw/gb_cfg.svh
//**********************************************************
// GB core configuration
// Reset values of PC and the register file, plus the width
// of the T-state counter used by the sequencer.
//**********************************************************

`ifndef GB_CFG_SVH
`define GB_CFG_SVH

`define GB_RESET_PC 16'h0000

// register state seen right after the boot rom hands over
`define GB_RESET_A 8'h11
`define GB_RESET_F 8'h80
`define GB_RESET_B 8'h00
`define GB_RESET_C 8'h00
`define GB_RESET_D 8'hFF
`define GB_RESET_E 8'h56
`define GB_RESET_H 8'h00
`define GB_RESET_L 8'h0D

`define GB_TCYCLE_W 5 // longest instruction is 16 clocks

`endif

// File: hw/gb_pkg.sv
//**********************************************************
// GB core types
// Vector types and enums shared by the CPU blocks.
//**********************************************************

`default_nettype none

`include "gb_cfg.svh"

package gb_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0] reg_sel_t; // opcode register field
	typedef logic [3:0] flags_t; // z n h c
	typedef logic [`GB_TCYCLE_W-1:0] tcycle_t;

	// register codes as they appear in opcode bits
	localparam reg_sel_t SEL_B = 3'd0;
	localparam reg_sel_t SEL_C = 3'd1;
	localparam reg_sel_t SEL_D = 3'd2;
	localparam reg_sel_t SEL_E = 3'd3;
	localparam reg_sel_t SEL_H = 3'd4;
	localparam reg_sel_t SEL_L = 3'd5;
	localparam reg_sel_t SEL_HL = 3'd6; // memory slot, no register behind it
	localparam reg_sel_t SEL_A = 3'd7;

	typedef enum logic [3:0] {
		ADD, ADC, SUB, SBC, AND, XOR, OR, SCF, CCF, CPL, PASS
	} alu_op_t;

	typedef enum logic [3:0] {
		NOP, LD_R_D8, LD_R_R, LD_R_HL, LD_HL_R, LD_HL_D8, INC_DEC,
		ALU_R, ALU_D8, FLAG_OP, JP, JR, HALT
	} instr_class_t;

	typedef enum logic {RUN, HALTED} cpu_state_t;

endpackage

`default_nettype wire

// File: hw/gb_alu.sv
//**********************************************************
// GB ALU
// 8-bit add, subtract, logic and flag operations with the
// Z N H C flag rules of the Game Boy CPU.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

module gb_alu import gb_pkg::*; (
	input byte_t a,
	input byte_t b,
	input alu_op_t op,
	input logic c_in,
	output byte_t result,
	output flags_t flags_out
);

	logic cin;
	logic [4:0] half;
	logic [8:0] full;
	logic n;
	logic h;
	logic cy;

	assign cin = ((op == ADC) || (op == SBC)) ? c_in : 1'b0; // carry only for adc/sbc

	always_comb begin
		half = '0;
		full = '0;
		result = b;
		n = 1'b0;
		h = 1'b0;
		cy = c_in;
		case (op)
			ADD, ADC: begin
				half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
				full = {1'b0, a} + {1'b0, b} + {8'b0, cin};
				result = full[7:0];
				h = half[4]; // carry out of bit 3
				cy = full[8];
			end
			SUB, SBC: begin
				half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
				full = {1'b0, a} - {1'b0, b} - {8'b0, cin};
				result = full[7:0];
				n = 1'b1;
				h = half[4]; // borrow from bit 4
				cy = full[8];
			end
			AND: begin
				result = a & b;
				h = 1'b1;
				cy = 1'b0;
			end
			XOR: begin
				result = a ^ b;
				cy = 1'b0;
			end
			OR: begin
				result = a | b;
				cy = 1'b0;
			end
			SCF: begin
				result = a;
				cy = 1'b1;
			end
			CCF: begin
				result = a;
				cy = ~c_in;
			end
			CPL: begin
				result = ~a;
				n = 1'b1;
				h = 1'b1;
			end
			default: result = b; // pass, used by the loads
		endcase
	end

	// z is meaningless for the flag ops, the sequencer keeps the old one
	assign flags_out = {result == 8'h00, n, h, cy};

endmodule

`default_nettype wire

// File: hw/gb_regfile.sv
//**********************************************************
// GB register file
// A B C D E H L and the flag nibble of F, one write port,
// one selectable read port plus direct A, H, L and flags.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

`include "gb_cfg.svh"

module gb_regfile import gb_pkg::*; (
	input logic clock,
	input logic rst,
	input reg_sel_t wr_sel,
	input byte_t wr_data,
	input logic wr_en,
	input logic flags_wr_en,
	input flags_t flags_wr_data,
	input reg_sel_t rd_sel,
	output byte_t rd_data,
	output byte_t a,
	output byte_t h,
	output byte_t l,
	output flags_t flags
);

	localparam byte_t RESET_F = `GB_RESET_F;

	byte_t b;
	byte_t c;
	byte_t d;
	byte_t e;

	always_ff @(posedge clock) begin
		if (rst) begin
			a <= `GB_RESET_A;
			b <= `GB_RESET_B;
			c <= `GB_RESET_C;
			d <= `GB_RESET_D;
			e <= `GB_RESET_E;
			h <= `GB_RESET_H;
			l <= `GB_RESET_L;
			flags <= RESET_F[7:4]; // low nibble of F is always zero
		end else begin
			if (wr_en) begin
				case (wr_sel)
					SEL_B: b <= wr_data;
					SEL_C: c <= wr_data;
					SEL_D: d <= wr_data;
					SEL_E: e <= wr_data;
					SEL_H: h <= wr_data;
					SEL_L: l <= wr_data;
					SEL_A: a <= wr_data;
					default: ; // (hl) slot, dropped
				endcase
			end
			if (flags_wr_en)
				flags <= flags_wr_data;
		end
	end

	always_comb begin
		case (rd_sel)
			SEL_B: rd_data = b;
			SEL_C: rd_data = c;
			SEL_D: rd_data = d;
			SEL_E: rd_data = e;
			SEL_H: rd_data = h;
			SEL_L: rd_data = l;
			SEL_A: rd_data = a;
			default: rd_data = 8'hFF; // (hl) reads float high
		endcase
	end

endmodule

`default_nettype wire

// File: hw/gb_decode.sv
//**********************************************************
// GB opcode decoder
// Maps an opcode to its instruction class, register fields,
// ALU operation, branch condition and length in T-states.
// Anything outside the supported groups decodes as nop.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

module gb_decode import gb_pkg::*; (
	input byte_t opcode,
	output instr_class_t iclass,
	output reg_sel_t dst_sel,
	output reg_sel_t src_sel,
	output alu_op_t alu_op,
	output logic [1:0] cond,
	output tcycle_t length
);

	alu_op_t grp_op;

	// ALU group op from bits 5:3, cp runs as sub
	always_comb begin
		case (opcode[5:3])
			3'd0: grp_op = ADD;
			3'd1: grp_op = ADC;
			3'd2: grp_op = SUB;
			3'd3: grp_op = SBC;
			3'd4: grp_op = AND;
			3'd5: grp_op = XOR;
			3'd6: grp_op = OR;
			default: grp_op = SUB;
		endcase
	end

	always_comb begin
		iclass = NOP;
		dst_sel = opcode[5:3];
		src_sel = opcode[2:0];
		alu_op = PASS;
		cond = opcode[4:3]; // nz z nc c
		length = tcycle_t'(4);
		casez (opcode)
			8'h76: iclass = HALT;
			8'h18, 8'h20, 8'h28, 8'h30, 8'h38: begin
				iclass = JR;
				length = tcycle_t'(8); // not-taken length
			end
			8'hC2, 8'hC3, 8'hCA, 8'hD2, 8'hDA: begin
				iclass = JP;
				length = tcycle_t'(12);
			end
			8'h2F, 8'h37, 8'h3F: begin
				iclass = FLAG_OP;
				dst_sel = SEL_A;
				alu_op = (opcode[4] == 1'b0) ? CPL : (opcode[3] ? CCF : SCF);
			end
			8'h36: begin
				iclass = LD_HL_D8;
				length = tcycle_t'(12);
			end
			8'b00??_?110: begin
				iclass = LD_R_D8;
				length = tcycle_t'(8);
			end
			8'b00??_?10?: begin
				if (opcode[5:3] != SEL_HL) begin // inc/dec (hl) is dropped
					iclass = INC_DEC;
					src_sel = opcode[5:3];
					alu_op = opcode[0] ? SUB : ADD;
				end
			end
			8'b01??_????: begin
				if (opcode[2:0] == SEL_HL) begin
					iclass = LD_R_HL;
					length = tcycle_t'(8);
				end else if (opcode[5:3] == SEL_HL) begin
					iclass = LD_HL_R;
					length = tcycle_t'(8);
				end else begin
					iclass = LD_R_R;
				end
			end
			8'b10??_????: begin
				if (opcode[2:0] != SEL_HL) begin
					iclass = ALU_R;
					dst_sel = (opcode[5:3] == 3'd7) ? SEL_HL : SEL_A; // cp result is thrown away
					alu_op = grp_op;
				end
			end
			8'b11??_?110: begin
				iclass = ALU_D8;
				dst_sel = (opcode[5:3] == 3'd7) ? SEL_HL : SEL_A;
				alu_op = grp_op;
				length = tcycle_t'(8);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/gb_control.sv
//**********************************************************
// GB sequencer
// Counts the T-states of each instruction, drives the bus
// strobes, PC and register writes, resolves branches and
// overlaps the next opcode fetch with the current one.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

`include "gb_cfg.svh"

module gb_control import gb_pkg::*; (
	input logic clock,
	input logic rst,
	input byte_t data_in,
	output addr_t addr,
	output byte_t data_out,
	output logic we,
	output logic re,
	output addr_t pc,
	output logic halted,
	output byte_t opcode,
	input instr_class_t iclass,
	input reg_sel_t dst_sel,
	input reg_sel_t src_sel,
	input alu_op_t alu_op,
	input logic [1:0] cond,
	input tcycle_t length,
	output reg_sel_t reg_rd_sel,
	input byte_t reg_rd_data,
	input byte_t reg_a,
	input byte_t reg_h,
	input byte_t reg_l,
	input flags_t flags,
	output reg_sel_t reg_wr_sel,
	output byte_t reg_wr_data,
	output logic reg_wr_en,
	output logic flags_wr_en,
	output flags_t flags_wr_data,
	output byte_t alu_a,
	output byte_t alu_b,
	output alu_op_t alu_op_out,
	input byte_t alu_result,
	input flags_t alu_flags
);

	cpu_state_t state;
	tcycle_t tcnt; // zero in the first clock of an instruction
	tcycle_t left;
	logic run;
	logic uncond;
	logic cond_met;
	logic taken;
	logic imm_rd;
	logic hl_rd;
	logic hl_wr;
	logic lo_now;
	logic tgt_now;
	logic wr_now;
	logic flg_now;
	logic jump;
	byte_t addr_latch;
	addr_t jmp_target;
	addr_t fetch_addr;

	assign run = (state == RUN);
	assign halted = (state == HALTED);

	// c3 and 18 are the unconditional forms
	assign uncond = (iclass == JP) ? opcode[0] : ~opcode[5];
	assign cond_met = cond[1] ? (flags[0] == cond[0]) : (flags[3] == cond[0]);
	assign taken = ((iclass == JP) || (iclass == JR)) && (uncond || cond_met);

	// taken branches run one machine cycle longer
	assign left = (tcnt == '0) ? tcycle_t'(length + (taken ? tcycle_t'(4) : tcycle_t'(0))) : tcnt;
	assign fetch_addr = jump ? jmp_target : pc;

	// per-class actions, keyed on the T-states left
	always_comb begin
		imm_rd = 1'b0;
		hl_rd = 1'b0;
		hl_wr = 1'b0;
		lo_now = 1'b0;
		tgt_now = 1'b0;
		wr_now = 1'b0;
		flg_now = 1'b0;
		if (run) begin
			case (iclass)
				LD_R_R: wr_now = (left == 4);
				INC_DEC, ALU_R, FLAG_OP: begin
					wr_now = (left == 4);
					flg_now = (left == 4);
				end
				LD_R_D8: begin
					imm_rd = (left == 8);
					wr_now = (left == 6);
				end
				LD_R_HL: begin
					hl_rd = (left == 8);
					wr_now = (left == 6);
				end
				ALU_D8: begin
					imm_rd = (left == 8);
					wr_now = (left == 6);
					flg_now = (left == 6);
				end
				LD_HL_R: hl_wr = (left == 8);
				LD_HL_D8: begin
					imm_rd = (left == 12);
					hl_wr = (left == 10); // immediate arrives here
				end
				JR: begin
					imm_rd = (left == 8);
					tgt_now = (left == 6);
				end
				JP: begin
					imm_rd = (left == 12) || (left == 10); // low then high byte
					lo_now = (left == 10);
					tgt_now = (left == 8);
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= RUN;
			pc <= `GB_RESET_PC;
			addr <= `GB_RESET_PC;
			tcnt <= '0;
			opcode <= 8'h00; // start with a nop whose fetch reads address 0
			re <= 1'b0;
			we <= 1'b0;
			jump <= 1'b0;
		end else begin
			re <= 1'b0;
			we <= 1'b0;
			if (run) begin
				tcnt <= left - 1'b1;
				if (imm_rd) begin
					addr <= pc;
					pc <= pc + 1'b1;
					re <= 1'b1;
				end
				if (hl_rd) begin
					addr <= {reg_h, reg_l};
					re <= 1'b1;
				end
				if (hl_wr) begin
					addr <= {reg_h, reg_l};
					we <= 1'b1;
				end
				if (tgt_now)
					jump <= taken;
				if (left == 3) begin // next opcode fetch
					addr <= fetch_addr;
					pc <= fetch_addr + 1'b1;
					re <= 1'b1;
				end
				if (left == 1) begin
					opcode <= data_in;
					jump <= 1'b0;
				end
				if ((iclass == HALT) && (left == 4))
					state <= HALTED; // stays until reset
			end
		end
	end

	always_ff @(posedge clock) begin
		if (hl_wr)
			data_out <= (iclass == LD_HL_D8) ? data_in : reg_rd_data;
		if (lo_now)
			addr_latch <= data_in;
		if (tgt_now) begin
			if (iclass == JP)
				jmp_target <= {data_in, addr_latch};
			else
				jmp_target <= pc + {{8{data_in[7]}}, data_in}; // pc already past offset
		end
	end

	assign reg_rd_sel = src_sel;
	assign reg_wr_sel = dst_sel;
	assign reg_wr_data = alu_result; // loads pass through the ALU
	assign reg_wr_en = wr_now;
	assign flags_wr_en = flg_now;
	assign alu_op_out = alu_op;
	assign alu_a = (iclass == INC_DEC) ? reg_rd_data : reg_a;

	always_comb begin
		case (iclass)
			INC_DEC: alu_b = 8'h01;
			ALU_R, LD_R_R: alu_b = reg_rd_data;
			default: alu_b = data_in;
		endcase
	end

	always_comb begin
		case (iclass)
			INC_DEC: flags_wr_data = {alu_flags[3:1], flags[0]}; // inc/dec keep c
			FLAG_OP: flags_wr_data = {flags[3], alu_flags[2:0]}; // z untouched
			default: flags_wr_data = alu_flags;
		endcase
	end

	a_bus_excl: assert property (@(posedge clock) disable iff (rst) !(we && re));
	a_tcnt_max: assert property (@(posedge clock) disable iff (rst) tcnt <= 16);

endmodule

`default_nettype wire

// File: hw/gb_cpu.sv
//**********************************************************
// GB CPU top
// Ties sequencer, decoder, register file and ALU together
// behind the byte-wide strobe bus.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

module gb_cpu import gb_pkg::*; (
	input logic clock,
	input logic rst,
	input byte_t data_in,
	output addr_t addr,
	output byte_t data_out,
	output logic we,
	output logic re,
	output addr_t pc,
	output logic halted
);

	byte_t opcode;
	instr_class_t iclass;
	reg_sel_t dst_sel;
	reg_sel_t src_sel;
	alu_op_t alu_op;
	logic [1:0] cond;
	tcycle_t length;
	reg_sel_t reg_rd_sel;
	byte_t reg_rd_data;
	byte_t reg_a;
	byte_t reg_h;
	byte_t reg_l;
	flags_t flags;
	reg_sel_t reg_wr_sel;
	byte_t reg_wr_data;
	logic reg_wr_en;
	logic flags_wr_en;
	flags_t flags_wr_data;
	byte_t alu_a;
	byte_t alu_b;
	alu_op_t alu_op_out;
	byte_t alu_result;
	flags_t alu_flags;

	gb_control u_control (
		.clock(clock), .rst(rst), .data_in(data_in), .addr(addr),
		.data_out(data_out), .we(we), .re(re), .pc(pc), .halted(halted),
		.opcode(opcode), .iclass(iclass), .dst_sel(dst_sel), .src_sel(src_sel),
		.alu_op(alu_op), .cond(cond), .length(length),
		.reg_rd_sel(reg_rd_sel), .reg_rd_data(reg_rd_data),
		.reg_a(reg_a), .reg_h(reg_h), .reg_l(reg_l), .flags(flags),
		.reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data), .reg_wr_en(reg_wr_en),
		.flags_wr_en(flags_wr_en), .flags_wr_data(flags_wr_data),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op_out(alu_op_out),
		.alu_result(alu_result), .alu_flags(alu_flags)
	);

	gb_decode u_decode (
		.opcode(opcode), .iclass(iclass), .dst_sel(dst_sel), .src_sel(src_sel),
		.alu_op(alu_op), .cond(cond), .length(length)
	);

	gb_regfile u_regfile (
		.clock(clock), .rst(rst), .wr_sel(reg_wr_sel), .wr_data(reg_wr_data),
		.wr_en(reg_wr_en), .flags_wr_en(flags_wr_en), .flags_wr_data(flags_wr_data),
		.rd_sel(reg_rd_sel), .rd_data(reg_rd_data),
		.a(reg_a), .h(reg_h), .l(reg_l), .flags(flags)
	);

	gb_alu u_alu (
		.a(alu_a), .b(alu_b), .op(alu_op_out), .c_in(flags[0]),
		.result(alu_result), .flags_out(alu_flags)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
//**********************************************************
// Testbench clock and reset
// Free running clock and a synchronous reset held high for
// the first few cycles.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 4, // ns
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0; // released on a rising edge
	end

endmodule

`default_nettype wire

// File: verif/tb_gb_cpu.sv
//**********************************************************
// GB CPU testbench
// 64 KB memory model with two-edge read latency, program
// and expected bus writes loaded from the stimulus file,
// write checking, halt checking and a watchdog.
//**********************************************************

`default_nettype none
`timescale 1ns/10ps

module tb_gb_cpu import gb_pkg::*; ();

	logic clock;
	logic rst;
	byte_t data_in;
	addr_t addr;
	byte_t data_out;
	logic we;
	logic re;
	addr_t pc;
	logic halted;

	byte_t mem [0:65535];
	addr_t exp_addr_q [$];
	byte_t exp_data_q [$];
	addr_t final_pc;
	logic final_pc_seen = 1'b0;
	logic loaded = 1'b0;
	int prog_bytes = 0;

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(3)) clk_gen (.clock(clock), .rst(rst));

	gb_cpu UUT (
		.clock(clock), .rst(rst), .data_in(data_in), .addr(addr),
		.data_out(data_out), .we(we), .re(re), .pc(pc), .halted(halted)
	);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t ns: %s expected %b got %b", $time, name, exp, got));
	endtask

	task automatic fill_memory();
		int i;
		for (i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h3C; // mixes both address bytes
	endtask

	task automatic load_stim();
		int fd;
		int code;
		logic done;
		logic [7:0] tag;
		logic [15:0] a;
		logic [7:0] d;
		logic [8*128-1:0] rest;
		done = 1'b0;
		fd = $fopen("verif/gb_stim.txt", "r");
		if (fd == 0)
			fail_now("cannot open the stimulus file verif/gb_stim.txt");
		while (!done) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				done = 1'b1;
			end else begin
				case (tag)
					"P": begin
						code = $fscanf(fd, "%h %h", a, d);
						mem[a] = d;
						prog_bytes++;
					end
					"W": begin
						code = $fscanf(fd, "%h %h", a, d);
						exp_addr_q.push_back(a);
						exp_data_q.push_back(d);
					end
					"E": begin
						code = $fscanf(fd, "%h", a);
						final_pc = a;
						final_pc_seen = 1'b1;
					end
					"#": code = $fgets(rest, fd); // comment line
					default: fail_now($sformatf("unknown record type %c in stimulus file", tag));
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic check_write();
		addr_t exp_a;
		byte_t exp_d;
		if (exp_addr_q.size() == 0)
			fail_now($sformatf("unexpected write of %h to %h at %0t ns", data_out, addr, $time));
		exp_a = exp_addr_q.pop_front();
		exp_d = exp_data_q.pop_front();
		check_addr("write addr", addr, exp_a);
		check_byte("data_out", data_out, exp_d);
	endtask

	// memory model with data_in one edge after re is seen
	always @(posedge clock) begin
		if (re === 1'b1 && we === 1'b1)
			fail_now("read and write strobes were high in the same clock");
		if (re === 1'b1)
			data_in <= mem[addr];
		if (we === 1'b1) begin
			mem[addr] <= data_out;
			check_write();
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded === 1'b1);
		limit = prog_bytes * 20 + 400;
		repeat (limit) @(posedge clock);
		fail_now($sformatf("timeout, the core did not halt within %0d clocks", limit));
	end

	initial begin : main_seq
		int cycles;
		data_in = 8'h00;
		fill_memory();
		load_stim();
		if (!final_pc_seen)
			fail_now("stimulus file has no final PC record");
		loaded = 1'b1;

		// idle bus after reset and first fetch from 0
		wait (rst === 1'b0);
		@(negedge clock);
		check_flag("we", we, 1'b0);
		check_flag("re", re, 1'b0);
		cycles = 0;
		while (re !== 1'b1 && cycles < 8) begin
			@(negedge clock);
			cycles++;
		end
		if (re !== 1'b1)
			fail_now("no opcode fetch after reset release");
		check_addr("addr", addr, 16'h0000);

		while (halted !== 1'b1)
			@(negedge clock);
		check_addr("pc", pc, final_pc);

		// core must stay quiet once halted
		repeat (32) begin
			@(negedge clock);
			check_flag("re", re, 1'b0);
			check_flag("we", we, 1'b0);
			check_flag("halted", halted, 1'b1);
			check_addr("pc", pc, final_pc);
		end
		if (exp_addr_q.size() != 0)
			fail_now($sformatf("%0d expected writes never happened", exp_addr_q.size()));

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/gb_stim.txt
# P addr byte = program byte, W addr data = expected bus write in order
# E addr = expected pc after halt, all values in hex
# loads and stores, hl = c010 then c011
P 0000 26
P 0001 C0
P 0002 2E
P 0003 10
P 0004 06
P 0005 5A
P 0006 70
P 0007 36
P 0008 A5
P 0009 2E
P 000A 11
P 000B 36
P 000C 3C
P 000D 7E
P 000E 4F
P 000F 0C
P 0010 71
P 0011 15
P 0012 72
# alu on b and on immediates, each result stored through ld (hl),a
P 0013 80
P 0014 77
P 0015 CE
P 0016 7A
P 0017 77
P 0018 88
P 0019 77
P 001A D6
P 001B 70
P 001C 77
P 001D 98
P 001E 77
P 001F 90
P 0020 77
P 0021 DE
P 0022 46
P 0023 77
P 0024 B0
P 0025 77
P 0026 E6
P 0027 F0
P 0028 77
P 0029 A8
P 002A 77
P 002B EE
P 002C FF
P 002D 77
P 002E A0
P 002F 77
P 0030 F6
P 0031 03
P 0032 77
P 0033 B8
P 0034 77
P 0035 FE
P 0036 53
P 0037 77
# conditional jr, scf and ccf, markers 01 02 on the paths taken
P 0038 20
P 0039 02
P 003A 36
P 003B 01
P 003C 28
P 003D 02
P 003E 36
P 003F EE
P 0040 37
P 0041 30
P 0042 02
P 0043 36
P 0044 02
P 0045 38
P 0046 02
P 0047 36
P 0048 EE
P 0049 3F
# conditional jp and cpl
P 004A DA
P 004B 00
P 004C 01
P 004D 36
P 004E 03
P 004F D2
P 0050 53
P 0051 00
P 0052 76
P 0053 2F
P 0054 77
P 0055 C2
P 0056 00
P 0057 01
P 0058 36
P 0059 04
P 005A CA
P 005B 5E
P 005C 00
P 005D 76
# stop and di run as nop
P 005E 10
P 005F F3
P 0060 36
P 0061 05
P 0062 C3
P 0063 66
P 0064 00
P 0065 76
# jr forward, jr backward, then halt
P 0066 18
P 0067 03
P 0068 77
P 0069 18
P 006A 03
P 006B 3C
P 006C 18
P 006D FA
P 006E 20
P 006F 01
P 0070 76
P 0071 76
W C010 5A
W C010 A5
W C011 3C
W C011 3D
W C011 FE
W C011 96
W C011 10
W C011 6B
W C011 FB
W C011 A0
W C011 46
W C011 00
W C011 5A
W C011 50
W C011 0A
W C011 F5
W C011 50
W C011 53
W C011 53
W C011 53
W C011 01
W C011 02
W C011 03
W C011 AC
W C011 04
W C011 05
W C011 AD
E 0072

// File: sources.f
+incdir+hw
hw/gb_pkg.sv
hw/gb_alu.sv
hw/gb_regfile.sv
hw/gb_decode.sv
hw/gb_control.sv
hw/gb_cpu.sv
verif/tb_clock_gen.sv
verif/tb_gb_cpu.sv
